//--- flist.f
+incdir+design
design/fetch_pkg.sv
design/word_memory.sv
design/bus_arbiter.sv
design/fetch_sequencer.sv
design/cmd_credit_queue.sv
design/cmd_fetch_top.sv
test/cmd_fetch_sva.sv
test/cmd_fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the command fetch testbench with Verilator and run it
# the run passes only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module cmd_fetch_tb -Mdir obj_dir -o cmd_fetch_sim &&
  ./obj_dir/cmd_fetch_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

//--- test/cmd_fetch_tb.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module cmd_fetch_tb;

  localparam int TIMEOUT = 200;
  localparam int QUIET = 60;
  // more than any run can deliver once run has dropped
  localparam int DRAIN_MAX = 16;
  localparam fetch_pkg::addr_t BASE_A = 'h10;
  localparam fetch_pkg::addr_t PTR_A = 'h40;
  localparam fetch_pkg::addr_t BASE_B = 'h80;
  localparam fetch_pkg::addr_t PTR_B = 'h60;
  localparam fetch_pkg::addr_t SCRATCH = 'hc0;

  logic             clk;
  logic             rst;
  logic             start;
  logic             run;
  fetch_pkg::addr_t base_addr;
  logic             busy;
  logic             host_req;
  logic             host_we;
  fetch_pkg::addr_t host_addr;
  fetch_pkg::data_t host_wdata;
  logic             host_rvalid;
  fetch_pkg::data_t host_rdata;
  logic             cmd_valid;
  fetch_pkg::addr_t cmd_addr;
  fetch_pkg::data_t cmd_word;
  logic             credit_return;

  // expected memory contents, follows every host write and IP write-back
  fetch_pkg::data_t model_mem [`MEM_DEPTH];
  // commands seen at the output, oldest first
  fetch_pkg::addr_t rx_addr [$];
  fetch_pkg::data_t rx_word [$];

  logic [31:0] lfsr_state;
  string       test_name;
  int          test_errors;
  int          errors;
  int          tests_run;
  int          tests_failed;
  // commands delivered by the sequential fetch run
  int          fetched;

  cmd_fetch_top i_cmd_fetch_top (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // consumer side monitor
  always @(negedge clk) begin
    if (!rst && cmd_valid) begin
      rx_addr.push_back(cmd_addr);
      rx_word.push_back(cmd_word);
    end
  end

  // fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check_addr(input string what, input fetch_pkg::addr_t exp,
                            input fetch_pkg::addr_t act);
    if (act !== exp) begin
      $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_data(input string what, input fetch_pkg::data_t exp,
                            input fetch_pkg::data_t act);
    if (act !== exp) begin
      $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s failed: %s", test_name, msg);
    test_errors++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s passed", test_name);
    end else begin
      $display("test %s failed with %0d errors", test_name, test_errors);
      tests_failed++;
      errors += test_errors;
    end
  endtask

  task automatic host_write(input fetch_pkg::addr_t a, input fetch_pkg::data_t d);
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= 1'b1;
    host_addr  <= a;
    host_wdata <= d;
    model_mem[a] = d;
    @(posedge clk);
    host_req <= 1'b0;
    host_we  <= 1'b0;
  endtask

  // read data is due exactly one cycle after the request
  task automatic host_read(input fetch_pkg::addr_t a, input fetch_pkg::data_t exp);
    @(posedge clk);
    host_req  <= 1'b1;
    host_we   <= 1'b0;
    host_addr <= a;
    @(posedge clk);
    host_req <= 1'b0;
    @(negedge clk);
    if (host_rvalid !== 1'b1) begin
      report_failure($sformatf("host_rvalid missing one cycle after read of %h", a));
    end
    check_data("host_rdata", exp, host_rdata);
  endtask

  task automatic start_fetch(input fetch_pkg::addr_t base);
    @(posedge clk);
    base_addr <= base;
    run       <= 1'b1;
    start     <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic return_credit();
    @(posedge clk);
    credit_return <= 1'b1;
    @(posedge clk);
    credit_return <= 1'b0;
  endtask

  task automatic consumer_take(output bit got, output fetch_pkg::addr_t a,
                               output fetch_pkg::data_t d, input bit give_credit,
                               input int limit);
    int n;
    n = 0;
    a = '0;
    d = '0;
    while (rx_addr.size() == 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    got = (rx_addr.size() != 0);
    if (got) begin
      a = rx_addr.pop_front();
      d = rx_word.pop_front();
      if (give_credit) begin
        return_credit();
      end
    end
  endtask

  // command k of a run must come from pointer plus k
  task automatic take_and_check(input fetch_pkg::addr_t ptr, inout int count,
                                input bit give_credit, input int limit, output bit got);
    fetch_pkg::addr_t a;
    fetch_pkg::data_t d;
    fetch_pkg::addr_t exp_addr;
    consumer_take(got, a, d, give_credit, limit);
    if (got) begin
      exp_addr = fetch_pkg::addr_t'((int'(ptr) + count) % `MEM_DEPTH);
      check_addr("cmd_addr", exp_addr, a);
      check_data("cmd_word", model_mem[exp_addr], d);
      count++;
    end
  endtask

  task automatic take_required(input fetch_pkg::addr_t ptr, inout int count,
                               input bit give_credit);
    bit got;
    take_and_check(ptr, count, give_credit, TIMEOUT, got);
    if (!got) begin
      report_failure("no command arrived within the timeout");
    end
  endtask

  // keep taking until the output stays quiet
  task automatic drain(input fetch_pkg::addr_t ptr, inout int count);
    bit got;
    int n;
    got = 1'b1;
    n = 0;
    while (got && n < DRAIN_MAX) begin
      take_and_check(ptr, count, 1'b1, QUIET, got);
      n++;
    end
    if (got) begin
      report_failure("commands kept arriving after run dropped");
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      report_failure("busy did not fall after run dropped");
    end
  endtask

  task automatic load_program(input fetch_pkg::addr_t base, input fetch_pkg::addr_t ptr,
                              input int n);
    host_write(fetch_pkg::addr_t'(base + `IP_OFFSET), fetch_pkg::data_t'(ptr));
    for (int i = 0; i < n; i++) begin
      host_write(fetch_pkg::addr_t'(ptr + i), fetch_pkg::data_t'(rand_bits(32)));
    end
  endtask

  // IP word must hold the pointer advanced once per delivered command
  task automatic check_ip(input fetch_pkg::addr_t base, input fetch_pkg::addr_t ptr,
                          input int count);
    fetch_pkg::addr_t ip;
    ip = fetch_pkg::addr_t'(base + `IP_OFFSET);
    model_mem[ip] = fetch_pkg::data_t'(fetch_pkg::addr_t'((int'(ptr) + count) % `MEM_DEPTH));
    host_read(ip, model_mem[ip]);
  endtask

  task automatic memory_access();
    begin_test("memory_access");
    for (int i = 0; i < 8; i++) begin
      host_write(fetch_pkg::addr_t'(SCRATCH + i), fetch_pkg::data_t'(rand_bits(32)));
    end
    for (int i = 0; i < 8; i++) begin
      host_read(fetch_pkg::addr_t'(SCRATCH + i), model_mem[SCRATCH + i]);
    end
    end_test();
  endtask

  task automatic sequential_fetch();
    int count;
    begin_test("sequential_fetch");
    count = 0;
    load_program(BASE_A, PTR_A, 32);
    start_fetch(BASE_A);
    for (int i = 0; i < 6; i++) begin
      take_required(PTR_A, count, 1'b1);
    end
    @(posedge clk);
    run <= 1'b0;
    drain(PTR_A, count);
    wait_idle();
    fetched = count;
    end_test();
  endtask

  task automatic ip_write_back();
    begin_test("ip_write_back");
    check_ip(BASE_A, PTR_A, fetched);
    end_test();
  endtask

  task automatic credit_backpressure();
    fetch_pkg::addr_t ptr;
    int               count;
    begin_test("credit_backpressure");
    ptr = fetch_pkg::addr_t'((int'(PTR_A) + fetched) % `MEM_DEPTH);
    count = 0;
    start_fetch(BASE_A);
    for (int i = 0; i < `CMD_CREDITS; i++) begin
      take_required(ptr, count, 1'b0);
    end
    repeat (QUIET) @(negedge clk);
    if (rx_addr.size() != 0) begin
      report_failure("command sent while no credits were held");
    end
    if (!busy) begin
      report_failure("sequencer went idle instead of stalling on a full queue");
    end
    @(posedge clk);
    run <= 1'b0;
    repeat (`CMD_CREDITS) return_credit();
    drain(ptr, count);
    wait_idle();
    // credits spent, queue full, plus the one held back by the sequencer
    if (count != `CMD_CREDITS + `Q_DEPTH + 1) begin
      $display("error: %s commands delivered expected %0d actual %0d", test_name,
               `CMD_CREDITS + `Q_DEPTH + 1, count);
      test_errors++;
    end
    check_ip(BASE_A, ptr, count);
    end_test();
  endtask

  task automatic host_interference();
    fetch_pkg::addr_t ha;
    int               count;
    begin_test("host_interference");
    count = 0;
    host_write(fetch_pkg::addr_t'(BASE_A + `IP_OFFSET), fetch_pkg::data_t'(PTR_A));
    start_fetch(BASE_A);
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          take_required(PTR_A, count, 1'b1);
        end
      end
      begin
        for (int i = 0; i < 10; i++) begin
          repeat (rand_bits(2)) @(posedge clk);
          ha = fetch_pkg::addr_t'(SCRATCH + rand_bits(3));
          host_read(ha, model_mem[ha]);
        end
      end
    join
    @(posedge clk);
    run <= 1'b0;
    drain(PTR_A, count);
    wait_idle();
    check_ip(BASE_A, PTR_A, count);
    end_test();
  endtask

  task automatic rebase_fetch();
    fetch_pkg::addr_t old_ip;
    int               count;
    begin_test("rebase_fetch");
    count = 0;
    old_ip = fetch_pkg::addr_t'(BASE_A + `IP_OFFSET);
    load_program(BASE_B, PTR_B, 16);
    start_fetch(BASE_B);
    for (int i = 0; i < 4; i++) begin
      take_required(PTR_B, count, 1'b1);
    end
    @(posedge clk);
    run <= 1'b0;
    drain(PTR_B, count);
    wait_idle();
    check_ip(BASE_B, PTR_B, count);
    // first IP word left alone
    host_read(old_ip, model_mem[old_ip]);
    end_test();
  endtask

  initial begin
    lfsr_state = 32'hb2253ac7;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    fetched = 0;
    rst = 1'b1;
    start = 1'b0;
    run = 1'b0;
    base_addr = '0;
    host_req = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    credit_return = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    memory_access();
    sequential_fetch();
    ip_write_back();
    credit_backpressure();
    host_interference();
    rebase_fetch();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- test/cmd_fetch_sva.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module cmd_fetch_sva (
  input logic                            clk,
  input logic                            rst,
  // queue side
  input logic                            cmd_valid,
  input logic                            credit_return,
  input logic [$clog2(`Q_DEPTH + 1)-1:0] credits,
  // arbiter side
  input logic                            host_req,
  input logic                            host_we,
  input logic                            host_rvalid,
  input logic                            fetch_gnt
);

  // sends and returned credits seen at the consumer port
  int sent;
  int returned;

  always_ff @(posedge clk) begin
    if (rst) begin
      sent     <= 0;
      returned <= 0;
    end else begin
      if (cmd_valid) begin
        sent <= sent + 1;
      end
      if (credit_return) begin
        returned <= returned + 1;
      end
    end
  end

  // a send needs a credit left over from earlier sends and returns
  send_needs_credit: assert property (@(posedge clk) disable iff (rst)
    cmd_valid |-> sent < `CMD_CREDITS + $past(returned))
    else $error("queue sent a command with zero credits");

  credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= `CMD_CREDITS)
    else $error("queue holds more credits than the consumer granted");

  // host always wins the memory port
  grant_excludes_host: assert property (@(posedge clk) disable iff (rst)
    !(fetch_gnt && host_req))
    else $error("fetcher granted while the host requested");

  host_read_returns: assert property (@(posedge clk) disable iff (rst)
    host_req && !host_we |=> host_rvalid)
    else $error("host_rvalid missing after a host read");

  host_rvalid_source: assert property (@(posedge clk) disable iff (rst)
    host_rvalid |-> $past(host_req && !host_we))
    else $error("host_rvalid without a host read the cycle before");

endmodule

bind cmd_credit_queue cmd_fetch_sva i_queue_sva (
  .clk, .rst, .cmd_valid, .credit_return, .credits,
  .host_req(1'b0), .host_we(1'b0), .host_rvalid(1'b0), .fetch_gnt(1'b0)
);

bind bus_arbiter cmd_fetch_sva i_arbiter_sva (
  .clk, .rst, .cmd_valid(1'b0), .credit_return(1'b0), .credits('0),
  .host_req, .host_we, .host_rvalid, .fetch_gnt
);

//--- design/cmd_fetch_top.sv
`timescale 1ns/100ps

module cmd_fetch_top (
  input  logic             clk,
  input  logic             rst,

  // fetch control
  input  logic             start,
  input  logic             run,
  input  fetch_pkg::addr_t base_addr,
  output logic             busy,

  // host memory access
  input  logic             host_req,
  input  logic             host_we,
  input  fetch_pkg::addr_t host_addr,
  input  fetch_pkg::data_t host_wdata,
  output logic             host_rvalid,
  output fetch_pkg::data_t host_rdata,

  // command output with credits
  output logic             cmd_valid,
  output fetch_pkg::addr_t cmd_addr,
  output fetch_pkg::data_t cmd_word,
  input  logic             credit_return
);

  // sequencer to arbiter
  logic             fetch_req;
  logic             fetch_we;
  fetch_pkg::addr_t fetch_addr;
  fetch_pkg::data_t fetch_wdata;
  logic             fetch_gnt;
  logic             fetch_rvalid;
  fetch_pkg::data_t fetch_rdata;

  // arbiter to memory
  logic             mem_en;
  logic             mem_we;
  fetch_pkg::addr_t mem_addr;
  fetch_pkg::data_t mem_wdata;
  fetch_pkg::data_t mem_rdata;

  // sequencer to queue
  logic             push;
  fetch_pkg::addr_t push_addr;
  fetch_pkg::data_t push_cmd;
  logic             space;

  bus_arbiter i_bus_arbiter (
    .clk, .rst,
    .host_req, .host_we, .host_addr, .host_wdata, .host_rvalid, .host_rdata,
    .fetch_req, .fetch_we, .fetch_addr, .fetch_wdata,
    .fetch_gnt, .fetch_rvalid, .fetch_rdata,
    .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
  );

  word_memory i_word_memory (
    .clk, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
  );

  fetch_sequencer i_fetch_sequencer (
    .clk, .rst, .start, .run, .base_addr, .busy,
    .fetch_req, .fetch_we, .fetch_addr, .fetch_wdata,
    .fetch_gnt, .fetch_rvalid, .fetch_rdata,
    .push, .push_addr, .push_cmd, .space
  );

  cmd_credit_queue i_cmd_credit_queue (
    .clk, .rst, .push, .push_addr, .push_cmd, .space,
    .cmd_valid, .cmd_addr, .cmd_word, .credit_return
  );

endmodule

//--- design/cmd_credit_queue.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module cmd_credit_queue (
  input  logic             clk,
  input  logic             rst,

  // from the sequencer
  input  logic             push,
  input  fetch_pkg::addr_t push_addr,
  input  fetch_pkg::data_t push_cmd,
  output logic             space,

  // to the consumer
  output logic             cmd_valid,
  output fetch_pkg::addr_t cmd_addr,
  output fetch_pkg::data_t cmd_word,
  input  logic             credit_return
);

  localparam int PTR_W = (`Q_DEPTH > 1) ? $clog2(`Q_DEPTH) : 1;
  localparam int CNT_W = $clog2(`Q_DEPTH + 1);

  fetch_pkg::addr_t addr_mem [`Q_DEPTH];
  fetch_pkg::data_t cmd_mem  [`Q_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] credits;

  logic             send;
  fetch_pkg::addr_t head_addr;
  fetch_pkg::data_t head_cmd;

  assign space = (count < CNT_W'(`Q_DEPTH));

  // empty queue forwards the entry being pushed
  assign send      = (count != '0 || push) && credits != '0;
  assign head_addr = (count != '0) ? addr_mem[rd_ptr] : push_addr;
  assign head_cmd  = (count != '0) ? cmd_mem[rd_ptr] : push_cmd;

  // entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr] <= push_addr;
      cmd_mem[wr_ptr]  <= push_cmd;
    end
  end

  // pointers, fill level and credits
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CNT_W'(`CMD_CREDITS);
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(`Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !send) begin
        count <= count + 1'b1;
      end else if (!push && send) begin
        count <= count - 1'b1;
      end
      if (credit_return && !send) begin
        credits <= credits + 1'b1;
      end else if (!credit_return && send) begin
        credits <= credits - 1'b1;
      end
    end
  end

  // output register
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      cmd_addr <= head_addr;
      cmd_word <= head_cmd;
    end
  end

endmodule

//--- design/fetch_sequencer.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_sequencer (
  input  logic             clk,
  input  logic             rst,

  // control
  input  logic             start,
  input  logic             run,
  input  fetch_pkg::addr_t base_addr,
  output logic             busy,

  // memory requests through the arbiter
  output logic             fetch_req,
  output logic             fetch_we,
  output fetch_pkg::addr_t fetch_addr,
  output fetch_pkg::data_t fetch_wdata,
  input  logic             fetch_gnt,
  input  logic             fetch_rvalid,
  input  fetch_pkg::data_t fetch_rdata,

  // command queue
  output logic             push,
  output fetch_pkg::addr_t push_addr,
  output fetch_pkg::data_t push_cmd,
  input  logic             space
);

  fetch_pkg::seq_state_t state_q;
  fetch_pkg::seq_state_t state_next;

  // base captured at start
  fetch_pkg::addr_t base_q;
  // location of the IP word
  fetch_pkg::addr_t ip_addr;
  // current command pointer, read from the IP word
  fetch_pkg::addr_t ptr_q;
  fetch_pkg::addr_t ptr_inc;
  // fetched command
  fetch_pkg::data_t cmd_q;

  assign ip_addr = base_q + fetch_pkg::addr_t'(`IP_OFFSET);

  // pointer wraps at the end of memory
  assign ptr_inc = (ptr_q == fetch_pkg::addr_t'(`MEM_DEPTH - 1)) ?
                   '0 : ptr_q + 1'b1;

  // next phase
  always_comb begin
    state_next = state_q;
    case (state_q)
      fetch_pkg::IDLE: begin
        if (start) begin
          state_next = fetch_pkg::READ_IP;
        end
      end
      fetch_pkg::READ_IP: begin
        if (fetch_gnt) begin
          state_next = fetch_pkg::WAIT_IP;
        end
      end
      fetch_pkg::WAIT_IP: begin
        if (fetch_rvalid) begin
          state_next = fetch_pkg::READ_CMD;
        end
      end
      fetch_pkg::READ_CMD: begin
        if (fetch_gnt) begin
          state_next = fetch_pkg::WAIT_CMD;
        end
      end
      fetch_pkg::WAIT_CMD: begin
        if (fetch_rvalid) begin
          state_next = fetch_pkg::PUSH;
        end
      end
      fetch_pkg::PUSH: begin
        // stall here while the queue is full
        if (space) begin
          state_next = fetch_pkg::WRITE_IP;
        end
      end
      fetch_pkg::WRITE_IP: begin
        if (fetch_gnt) begin
          state_next = run ? fetch_pkg::READ_IP : fetch_pkg::IDLE;
        end
      end
      default: begin
        state_next = fetch_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fetch_pkg::IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  // base, pointer and command capture
  always_ff @(posedge clk) begin
    if (state_q == fetch_pkg::IDLE && start) begin
      base_q <= base_addr;
    end
    if (state_q == fetch_pkg::WAIT_IP && fetch_rvalid) begin
      ptr_q <= fetch_pkg::addr_t'(fetch_rdata[`ADDR_W-1:0]);
    end else if (push) begin
      ptr_q <= ptr_inc;
    end
    if (state_q == fetch_pkg::WAIT_CMD && fetch_rvalid) begin
      cmd_q <= fetch_rdata;
    end
  end

  // memory request decode
  assign fetch_req = (state_q == fetch_pkg::READ_IP) ||
                     (state_q == fetch_pkg::READ_CMD) ||
                     (state_q == fetch_pkg::WRITE_IP);
  assign fetch_we    = (state_q == fetch_pkg::WRITE_IP);
  assign fetch_addr  = (state_q == fetch_pkg::READ_CMD) ? ptr_q : ip_addr;
  // pointer already advanced by the push
  assign fetch_wdata = fetch_pkg::data_t'(ptr_q);

  // push tagged with the command address
  assign push      = (state_q == fetch_pkg::PUSH) && space;
  assign push_addr = ptr_q;
  assign push_cmd  = cmd_q;

  assign busy = (state_q != fetch_pkg::IDLE);

endmodule

//--- design/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
  input  logic             clk,
  input  logic             rst,

  // host side, never stalled
  input  logic             host_req,
  input  logic             host_we,
  input  fetch_pkg::addr_t host_addr,
  input  fetch_pkg::data_t host_wdata,
  output logic             host_rvalid,
  output fetch_pkg::data_t host_rdata,

  // fetcher side, holds its request until granted
  input  logic             fetch_req,
  input  logic             fetch_we,
  input  fetch_pkg::addr_t fetch_addr,
  input  fetch_pkg::data_t fetch_wdata,
  output logic             fetch_gnt,
  output logic             fetch_rvalid,
  output fetch_pkg::data_t fetch_rdata,

  // memory port
  output logic             mem_en,
  output logic             mem_we,
  output fetch_pkg::addr_t mem_addr,
  output fetch_pkg::data_t mem_wdata,
  input  fetch_pkg::data_t mem_rdata
);

  // read owners for the data coming back next cycle
  logic host_rd_q;
  logic fetch_rd_q;

  // host has priority
  assign fetch_gnt = fetch_req && !host_req;

  // memory port mux
  assign mem_en    = host_req || fetch_req;
  assign mem_we    = host_req ? host_we : fetch_we;
  assign mem_addr  = host_req ? host_addr : fetch_addr;
  assign mem_wdata = host_req ? host_wdata : fetch_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      host_rd_q  <= 1'b0;
      fetch_rd_q <= 1'b0;
    end else begin
      host_rd_q  <= host_req && !host_we;
      fetch_rd_q <= fetch_gnt && !fetch_we;
    end
  end

  // route returning data to whoever issued the read
  assign host_rvalid  = host_rd_q;
  assign fetch_rvalid = fetch_rd_q;
  assign host_rdata   = host_rd_q ? mem_rdata : '0;
  assign fetch_rdata  = fetch_rd_q ? mem_rdata : '0;

endmodule

//--- design/word_memory.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module word_memory (
  input  logic             clk,
  input  logic             mem_en,
  input  logic             mem_we,
  input  fetch_pkg::addr_t mem_addr,
  input  fetch_pkg::data_t mem_wdata,
  output fetch_pkg::data_t mem_rdata
);

  // storage array
  fetch_pkg::data_t mem [`MEM_DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (mem_en && mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  // registered read, data valid the cycle after the request
  always_ff @(posedge clk) begin
    if (mem_en && !mem_we) begin
      mem_rdata <= mem[mem_addr];
    end
  end

endmodule

//--- design/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

  // word address into the shared memory
  typedef logic [`ADDR_W-1:0] addr_t;

  // memory word, also the command word
  typedef logic [`DATA_W-1:0] data_t;

  // sequencer phases, one command per pass through READ_IP .. WRITE_IP
  typedef enum logic [2:0] {
    // waiting for start
    IDLE,
    // request the IP word
    READ_IP,
    // pointer comes back
    WAIT_IP,
    // request the command at the pointer
    READ_CMD,
    // command comes back
    WAIT_CMD,
    // hand command to the queue
    PUSH,
    // store the incremented pointer
    WRITE_IP
  } seq_state_t;

endpackage

//--- design/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// word address width
`define ADDR_W 8

// memory and command word width
`define DATA_W 32

// number of words in the shared memory
`define MEM_DEPTH 256

// IP word location relative to the base address
`define IP_OFFSET 0

// command queue entries
`define Q_DEPTH 4

// credits held by the queue after reset, at most Q_DEPTH
`define CMD_CREDITS 2

`endif
